// File: hw/ising_pkg.sv
// Ising problem package.
// Sizes and value types shared by the register block and the annealing core
// of the 8-spin Ising machine.

package ising_pkg;

  // problem size.
  localparam int unsigned NumSpins = 8;
  localparam int unsigned NumCouplings = NumSpins * NumSpins;

  // weight widths, two's complement.
  localparam int unsigned CouplingWidth = 4;
  localparam int unsigned BiasWidth = 4;
  localparam int unsigned FieldWidth = 8;
  localparam int unsigned SweepCntWidth = 8;

  // bit i set means spin i is +1, clear means -1.
  typedef logic [NumSpins-1:0] spin_vec_t;

  // one entry of the coupling matrix J.
  typedef logic signed [CouplingWidth-1:0] coupling_t;

  // one local bias h_i.
  typedef logic signed [BiasWidth-1:0] bias_t;

  // local field sum, holds seven couplings plus a bias without overflow.
  typedef logic signed [FieldWidth-1:0] field_t;

  // number of annealing sweeps requested by the host.
  typedef logic [SweepCntWidth-1:0] sweep_cnt_t;

  // spin pointer.
  typedef logic [$clog2(NumSpins)-1:0] spin_idx_t;

endpackage : ising_pkg

// File: hw/uart_pkg.sv
// UART link and command protocol package.
// Baud timing, the host opcodes and the state encodings of the receiver
// and the command decoder.

package uart_pkg;

  // clock cycles per UART bit.
  localparam int unsigned ClksPerBit = 4;
  // start bit, 8 data bits and stop bit.
  localparam int unsigned FrameBits = 10;

  typedef logic [7:0] byte_t;
  typedef logic [$clog2(ClksPerBit)-1:0] baud_cnt_t;

  // host command opcodes, sent as the first byte of each command.
  typedef enum logic [7:0] {
    CmdWriteJ     = 8'h01,
    CmdWriteH     = 8'h02,
    CmdWriteSpins = 8'h03,
    CmdRun        = 8'h04,
    CmdReadSpins  = 8'h05
  } cmd_op_e;

  typedef enum logic [1:0] {
    RxIdle,
    RxStart,
    RxData,
    RxStop
  } rx_state_e;

  typedef enum logic [1:0] {
    DecOpcode,
    DecOperand,
    DecValue
  } dec_state_e;

endpackage : uart_pkg

// File: hw/anneal_if.sv
// Register block to annealing core link.
// Carries the problem data and the start pulse one way and the live spins
// and busy flag back.

interface anneal_if;

  ising_pkg::coupling_t  j_flat [ising_pkg::NumCouplings];
  ising_pkg::bias_t      h_vec [ising_pkg::NumSpins];
  ising_pkg::spin_vec_t  spins_init;
  ising_pkg::sweep_cnt_t sweeps;
  logic                  start;

  ising_pkg::spin_vec_t  spins_out;
  logic                  busy;

  modport regs (
    output j_flat, h_vec, spins_init, sweeps, start,
    input  spins_out, busy
  );

  modport core (
    input  j_flat, h_vec, spins_init, sweeps, start,
    output spins_out, busy
  );

endinterface : anneal_if

// File: hw/uart_rx.sv
// UART receiver, 8N1.
// Samples each bit in its middle and emits one byte strobe per good frame.

module uart_rx (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            rx_i,
  output uart_pkg::byte_t data_o,
  output logic            valid_o
);

  uart_pkg::rx_state_e state_q;
  uart_pkg::baud_cnt_t cnt_q;
  logic [2:0]          bit_q;
  uart_pkg::byte_t     shift_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= uart_pkg::RxIdle;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_o <= 1'b0;
    end else begin
      valid_o <= 1'b0;
      unique case (state_q)
        uart_pkg::RxIdle: begin
          if (!rx_i) begin
            state_q <= uart_pkg::RxStart;
            cnt_q   <= '0;
          end
        end
        // wait half a bit, then make sure the line is still low.
        uart_pkg::RxStart: begin
          if (cnt_q == uart_pkg::baud_cnt_t'(uart_pkg::ClksPerBit / 2 - 1)) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= rx_i ? uart_pkg::RxIdle : uart_pkg::RxData;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        uart_pkg::RxData: begin
          if (cnt_q == uart_pkg::baud_cnt_t'(uart_pkg::ClksPerBit - 1)) begin
            cnt_q   <= '0;
            shift_q <= {rx_i, shift_q[7:1]};
            bit_q   <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= uart_pkg::RxStop;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        // a low stop bit is a framing error, the byte is dropped.
        uart_pkg::RxStop: begin
          if (cnt_q == uart_pkg::baud_cnt_t'(uart_pkg::ClksPerBit - 1)) begin
            cnt_q   <= '0;
            valid_o <= rx_i;
            state_q <= uart_pkg::RxIdle;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= uart_pkg::RxIdle;
      endcase
    end
  end

  assign data_o = shift_q;

endmodule : uart_rx

// File: hw/uart_tx.sv
// UART transmitter, 8N1.
// Shifts out start bit, data LSB first and stop bit from one frame register.

module uart_tx (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  uart_pkg::byte_t data_i,
  input  logic            start_i,
  output logic            tx_o,
  output logic            busy_o
);

  logic [uart_pkg::FrameBits-1:0] frame_q;
  uart_pkg::baud_cnt_t            cnt_q;
  logic [3:0]                     bit_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // all ones keeps the line idle high.
      frame_q <= '1;
      cnt_q   <= '0;
      bit_q   <= '0;
      busy_o  <= 1'b0;
    end else if (!busy_o) begin
      if (start_i) begin
        frame_q <= {1'b1, data_i, 1'b0};
        cnt_q   <= '0;
        bit_q   <= '0;
        busy_o  <= 1'b1;
      end
    end else begin
      if (cnt_q == uart_pkg::baud_cnt_t'(uart_pkg::ClksPerBit - 1)) begin
        cnt_q   <= '0;
        frame_q <= {1'b1, frame_q[uart_pkg::FrameBits-1:1]};
        // last bit period over, the stop bit is done.
        if (bit_q == 4'(uart_pkg::FrameBits - 1)) begin
          busy_o <= 1'b0;
        end else begin
          bit_q <= bit_q + 1'b1;
        end
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign tx_o = frame_q[0];

endmodule : uart_tx

// File: hw/ising_regs.sv
// Ising register block.
// Decodes host commands, keeps J, h, initial spins and sweep count for the
// core, starts runs and queues spin read replies.

module ising_regs (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  uart_pkg::byte_t rx_data_i,
  input  logic            rx_valid_i,
  output uart_pkg::byte_t tx_data_o,
  output logic            tx_start_o,
  input  logic            tx_busy_i,
  anneal_if.regs          core
);

  uart_pkg::dec_state_e  state_q;
  uart_pkg::cmd_op_e     op_q;
  uart_pkg::byte_t       arg_q;
  ising_pkg::coupling_t  j_q [ising_pkg::NumCouplings];
  ising_pkg::bias_t      h_q [ising_pkg::NumSpins];
  ising_pkg::spin_vec_t  spins_q;
  ising_pkg::sweep_cnt_t sweeps_q;
  logic                  start_q;
  logic                  busy_q;
  ising_pkg::spin_idx_t  row;
  ising_pkg::spin_idx_t  col;
  logic                  read_req;
  logic                  read_pend_q;
  logic                  issue;
  ising_pkg::spin_vec_t  reply_spins;

  // operand byte of a J write is i*8+j.
  assign row = arg_q[5:3];
  assign col = arg_q[2:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= uart_pkg::DecOpcode;
      op_q     <= uart_pkg::CmdReadSpins;
      arg_q    <= '0;
      spins_q  <= '0;
      sweeps_q <= '0;
      start_q  <= 1'b0;
      busy_q   <= 1'b0;
      for (int k = 0; k < ising_pkg::NumCouplings; k++) begin
        j_q[k] <= '0;
      end
      for (int k = 0; k < ising_pkg::NumSpins; k++) begin
        h_q[k] <= '0;
      end
    end else begin
      start_q <= 1'b0;
      busy_q  <= core.busy;
      // keep the annealed state as the start point of the next run.
      if (busy_q && !core.busy) begin
        spins_q <= core.spins_out;
      end
      if (rx_valid_i) begin
        unique case (state_q)
          uart_pkg::DecOpcode: begin
            case (uart_pkg::cmd_op_e'(rx_data_i))
              uart_pkg::CmdWriteJ, uart_pkg::CmdWriteH,
              uart_pkg::CmdWriteSpins, uart_pkg::CmdRun: begin
                op_q    <= uart_pkg::cmd_op_e'(rx_data_i);
                state_q <= uart_pkg::DecOperand;
              end
              // reads go to the reply logic, unknown opcodes are ignored.
              default: state_q <= uart_pkg::DecOpcode;
            endcase
          end
          uart_pkg::DecOperand: begin
            arg_q   <= rx_data_i;
            state_q <= uart_pkg::DecOpcode;
            case (op_q)
              uart_pkg::CmdWriteJ, uart_pkg::CmdWriteH: begin
                state_q <= uart_pkg::DecValue;
              end
              uart_pkg::CmdWriteSpins: begin
                if (!core.busy) begin
                  spins_q <= rx_data_i;
                end
              end
              uart_pkg::CmdRun: begin
                if (!core.busy) begin
                  sweeps_q <= rx_data_i;
                  start_q  <= 1'b1;
                end
              end
              default: state_q <= uart_pkg::DecOpcode;
            endcase
          end
          uart_pkg::DecValue: begin
            state_q <= uart_pkg::DecOpcode;
            if (!core.busy) begin
              // J is kept symmetric.
              if (op_q == uart_pkg::CmdWriteJ && arg_q < ising_pkg::NumCouplings) begin
                j_q[row * ising_pkg::NumSpins + col] <= ising_pkg::coupling_t'(rx_data_i[3:0]);
                j_q[col * ising_pkg::NumSpins + row] <= ising_pkg::coupling_t'(rx_data_i[3:0]);
              end else if (op_q == uart_pkg::CmdWriteH && arg_q < ising_pkg::NumSpins) begin
                h_q[col] <= ising_pkg::bias_t'(rx_data_i[3:0]);
              end
            end
          end
          default: state_q <= uart_pkg::DecOpcode;
        endcase
      end
    end
  end

  assign core.j_flat     = j_q;
  assign core.h_vec      = h_q;
  assign core.spins_init = spins_q;
  assign core.sweeps     = sweeps_q;
  assign core.start      = start_q;

  assign read_req = rx_valid_i && state_q == uart_pkg::DecOpcode &&
                    rx_data_i == uart_pkg::byte_t'(uart_pkg::CmdReadSpins);

  // live spins while running and in the cycle busy falls, else the store.
  assign reply_spins = (core.busy || busy_q) ? core.spins_out : spins_q;

  // one read can wait for the transmitter, later ones are dropped.
  assign issue = (read_req || read_pend_q) && !tx_busy_i && !tx_start_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_start_o  <= 1'b0;
      read_pend_q <= 1'b0;
    end else begin
      tx_start_o <= issue;
      if (issue) begin
        read_pend_q <= 1'b0;
      end else if (read_req) begin
        read_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      tx_data_o <= reply_spins;
    end
  end

endmodule : ising_regs

// File: hw/anneal_core.sv
// Zero-temperature annealing core.
// Updates one spin per cycle in index order, each to the sign of its local
// field, for the requested number of sweeps.

module anneal_core (
  input logic    clk_i,
  input logic    rst_n_i,
  anneal_if.core cfg
);

  ising_pkg::spin_vec_t  spins_q;
  ising_pkg::spin_idx_t  idx_q;
  ising_pkg::sweep_cnt_t sweeps_left_q;
  logic                  busy_q;
  ising_pkg::field_t     field;

  // local field of the spin under the pointer, self coupling skipped.
  always_comb begin
    field = ising_pkg::field_t'(cfg.h_vec[idx_q]);
    for (int j = 0; j < ising_pkg::NumSpins; j++) begin
      if (j != int'(idx_q)) begin
        if (spins_q[j]) begin
          field = field + ising_pkg::field_t'(cfg.j_flat[int'(idx_q) * ising_pkg::NumSpins + j]);
        end else begin
          field = field - ising_pkg::field_t'(cfg.j_flat[int'(idx_q) * ising_pkg::NumSpins + j]);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      idx_q         <= '0;
      sweeps_left_q <= '0;
      busy_q        <= 1'b0;
    end else if (!busy_q) begin
      // a zero sweep count leaves the core idle.
      if (cfg.start && cfg.sweeps != '0) begin
        idx_q         <= '0;
        sweeps_left_q <= cfg.sweeps;
        busy_q        <= 1'b1;
      end
    end else begin
      idx_q <= idx_q + 1'b1;
      if (idx_q == ising_pkg::spin_idx_t'(ising_pkg::NumSpins - 1)) begin
        sweeps_left_q <= sweeps_left_q - 1'b1;
        if (sweeps_left_q == ising_pkg::sweep_cnt_t'(1)) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // in place update, later spins of a sweep see the new values.
  always_ff @(posedge clk_i) begin
    if (!busy_q) begin
      if (cfg.start && cfg.sweeps != '0) begin
        spins_q <= cfg.spins_init;
      end
    end else if (field > 0) begin
      spins_q[idx_q] <= 1'b1;
    end else if (field < 0) begin
      spins_q[idx_q] <= 1'b0;
    end
  end

  assign cfg.spins_out = spins_q;
  assign cfg.busy      = busy_q;

endmodule : anneal_core

// File: hw/ising_top.sv
// Ising machine top level.
// UART receiver and transmitter, the command register block and the
// annealing core.

module ising_top (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic busy_o
);

  uart_pkg::byte_t rx_data;
  logic            rx_valid;
  uart_pkg::byte_t tx_data;
  logic            tx_start;
  logic            tx_busy;

  anneal_if anneal ();

  uart_rx u_rx (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rx_i    (uart_rx_i),
    .data_o  (rx_data),
    .valid_o (rx_valid)
  );

  uart_tx u_tx (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (tx_data),
    .start_i (tx_start),
    .tx_o    (uart_tx_o),
    .busy_o  (tx_busy)
  );

  ising_regs u_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rx_data_i  (rx_data),
    .rx_valid_i (rx_valid),
    .tx_data_o  (tx_data),
    .tx_start_o (tx_start),
    .tx_busy_i  (tx_busy),
    .core       (anneal.regs)
  );

  anneal_core u_core (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cfg     (anneal.core)
  );

  assign busy_o = anneal.busy;

endmodule : ising_top

// File: tb/tb_clock.sv
// Testbench clock source.
// Free running clock with a 100 ns period.

module tb_clock (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial clk_o = 1'b0;

  always #50 clk_o = ~clk_o;

endmodule : tb_clock

// File: tb/tb_ising_top.sv
// Ising machine testbench.
// Plays the host on the UART pins, loads problems, runs sweeps and checks
// the returned spins against a software model of the ordered update rule.

module tb_ising_top;

  timeunit 1ns;
  timeprecision 1ps;

  // about 840 frames of 40 cycles plus ten runs of at most 255 sweeps, with margin.
  localparam int TimeoutCycles = 60000;
  localparam int FrameCycles = uart_pkg::ClksPerBit * uart_pkg::FrameBits;

  logic clk;
  logic rst_n_i;
  logic uart_rx_i;
  logic uart_tx_o;
  logic busy_o;
  int   cycle_count = 0;

  // host side mirror of the problem loaded into the DUT.
  int                   j_model [ising_pkg::NumSpins][ising_pkg::NumSpins];
  int                   h_model [ising_pkg::NumSpins];
  ising_pkg::spin_vec_t spins_model;

  tb_clock u_clock (
    .clk_o (clk)
  );

  ising_top dut0 (
    .clk_i     (clk),
    .rst_n_i   (rst_n_i),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o),
    .busy_o    (busy_o)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopping after the first error");
  endtask

  task automatic check_spins(input string name, input ising_pkg::spin_vec_t exp,
                             input ising_pkg::spin_vec_t act);
    if (act !== exp) begin
      fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_busy(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("CHECK FAILED %s busy expected %b actual %b", name, exp, act));
    end
  endtask

  // start bit, 8 data bits LSB first, stop bit.
  task automatic send_byte(input uart_pkg::byte_t data);
    logic [uart_pkg::FrameBits-1:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int b = 0; b < uart_pkg::FrameBits; b++) begin
      @(posedge clk);
      uart_rx_i <= frame[b];
      repeat (uart_pkg::ClksPerBit - 1) @(posedge clk);
    end
  endtask

  // line is sampled on the falling clock edge, away from the DUT updates.
  task automatic recv_byte(output uart_pkg::byte_t data);
    int wait_cycles;
    wait_cycles = 0;
    @(negedge clk);
    while (uart_tx_o !== 1'b0) begin
      wait_cycles++;
      if (wait_cycles > 20 * FrameCycles) begin
        fail_run("no reply byte from the DUT");
      end
      @(negedge clk);
    end
    repeat (uart_pkg::ClksPerBit / 2) @(negedge clk);
    for (int b = 0; b < 8; b++) begin
      repeat (uart_pkg::ClksPerBit) @(negedge clk);
      data[b] = uart_tx_o;
    end
    repeat (uart_pkg::ClksPerBit) @(negedge clk);
    if (uart_tx_o !== 1'b1) begin
      fail_run("reply frame from the DUT has a low stop bit");
    end
  endtask

  task automatic write_j(input int i, input int j, input ising_pkg::coupling_t val);
    send_byte(uart_pkg::byte_t'(uart_pkg::CmdWriteJ));
    send_byte(uart_pkg::byte_t'(i * ising_pkg::NumSpins + j));
    send_byte(uart_pkg::byte_t'(val));
    j_model[i][j] = val;
    j_model[j][i] = val;
  endtask

  task automatic write_h(input int i, input ising_pkg::bias_t val);
    send_byte(uart_pkg::byte_t'(uart_pkg::CmdWriteH));
    send_byte(uart_pkg::byte_t'(i));
    send_byte(uart_pkg::byte_t'(val));
    h_model[i] = val;
  endtask

  task automatic write_spins(input ising_pkg::spin_vec_t val);
    send_byte(uart_pkg::byte_t'(uart_pkg::CmdWriteSpins));
    send_byte(uart_pkg::byte_t'(val));
    spins_model = val;
  endtask

  task automatic read_spins(output ising_pkg::spin_vec_t val);
    uart_pkg::byte_t data;
    send_byte(uart_pkg::byte_t'(uart_pkg::CmdReadSpins));
    recv_byte(data);
    val = ising_pkg::spin_vec_t'(data);
  endtask

  // reference: spins in index order, each to the sign of its field.
  task automatic model_anneal(input int sweeps);
    int field;
    for (int s = 0; s < sweeps; s++) begin
      for (int i = 0; i < ising_pkg::NumSpins; i++) begin
        field = h_model[i];
        for (int j = 0; j < ising_pkg::NumSpins; j++) begin
          if (j != i) begin
            field += spins_model[j] ? j_model[i][j] : -j_model[i][j];
          end
        end
        if (field > 0) begin
          spins_model[i] = 1'b1;
        end else if (field < 0) begin
          spins_model[i] = 1'b0;
        end
      end
    end
  endtask

  task automatic run_sweeps(input int sweeps);
    send_byte(uart_pkg::byte_t'(uart_pkg::CmdRun));
    send_byte(uart_pkg::byte_t'(sweeps));
    model_anneal(sweeps);
  endtask

  task automatic wait_busy_high();
    int n;
    n = 0;
    @(negedge clk);
    while (busy_o !== 1'b1) begin
      n++;
      if (n > 4) begin
        fail_run("busy_o never rose after a run command");
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_busy_low();
    int n;
    n = 0;
    while (busy_o !== 1'b0) begin
      n++;
      if (n > 255 * ising_pkg::NumSpins + 4) begin
        fail_run("busy_o stayed high longer than the longest run");
      end
      @(negedge clk);
    end
  endtask

  task automatic test_reset();
    ising_pkg::spin_vec_t got;
    @(negedge clk);
    check_busy("reset", 1'b0, busy_o);
    if (uart_tx_o !== 1'b1) begin
      fail_run("uart_tx_o is not idle high after reset");
    end
    read_spins(got);
    check_spins("reset", 8'h00, got);
  endtask

  task automatic test_spin_write();
    ising_pkg::spin_vec_t got;
    write_spins(ising_pkg::spin_vec_t'($urandom_range(255, 0)));
    read_spins(got);
    check_spins("spin_write", spins_model, got);
  endtask

  task automatic test_ferro_run();
    ising_pkg::spin_vec_t got;
    for (int i = 0; i < ising_pkg::NumSpins; i++) begin
      for (int j = i + 1; j < ising_pkg::NumSpins; j++) begin
        write_j(i, j, 4'sd1);
      end
    end
    write_spins(8'h01);
    run_sweeps(1);
    wait_busy_high();
    // one sweep keeps the core busy for exactly one cycle per spin.
    for (int c = 0; c < ising_pkg::NumSpins; c++) begin
      check_busy("ferro_run", 1'b1, busy_o);
      @(negedge clk);
    end
    check_busy("ferro_run", 1'b0, busy_o);
    read_spins(got);
    check_spins("ferro_run", spins_model, got);
    check_spins("ferro_run", 8'h00, got);
  endtask

  task automatic test_random_problems();
    ising_pkg::spin_vec_t got;
    for (int p = 0; p < 5; p++) begin
      // diagonal entries are loaded too, the core must skip them.
      for (int i = 0; i < ising_pkg::NumSpins; i++) begin
        for (int j = i; j < ising_pkg::NumSpins; j++) begin
          write_j(i, j, ising_pkg::coupling_t'($urandom_range(15, 0)));
        end
        write_h(i, ising_pkg::bias_t'($urandom_range(15, 0)));
      end
      write_spins(ising_pkg::spin_vec_t'($urandom_range(255, 0)));
      run_sweeps($urandom_range(4, 1));
      wait_busy_high();
      wait_busy_low();
      read_spins(got);
      check_spins($sformatf("random_problem_%0d", p), spins_model, got);
    end
  endtask

  task automatic test_continue_run();
    ising_pkg::spin_vec_t got;
    write_spins(ising_pkg::spin_vec_t'($urandom_range(255, 0)));
    for (int r = 0; r < 2; r++) begin
      run_sweeps(2);
      wait_busy_high();
      wait_busy_low();
      read_spins(got);
      check_spins($sformatf("continue_run_%0d", r), spins_model, got);
    end
  endtask

  task automatic test_dropped_cmds();
    ising_pkg::spin_vec_t got;
    // spin 1 decoupled and biased down, so only h[1] decides its sign.
    for (int j = 0; j < ising_pkg::NumSpins; j++) begin
      write_j(1, j, 4'sd0);
    end
    write_h(1, ising_pkg::bias_t'(-8));
    run_sweeps(32);
    wait_busy_high();
    // the model is left alone, these bytes must not reach the stores.
    send_byte(uart_pkg::byte_t'(uart_pkg::CmdWriteSpins));
    send_byte(~spins_model);
    send_byte(uart_pkg::byte_t'(uart_pkg::CmdWriteH));
    send_byte(8'd1);
    send_byte(8'h05);
    @(negedge clk);
    check_busy("dropped_cmds", 1'b1, busy_o);
    wait_busy_low();
    send_byte(uart_pkg::byte_t'(uart_pkg::CmdWriteH));
    send_byte(8'd9);
    send_byte(8'h05);
    send_byte(8'h7F);
    // a stored h[1] of +5 would turn spin 1 up in this run.
    run_sweeps(1);
    wait_busy_high();
    wait_busy_low();
    read_spins(got);
    check_spins("dropped_cmds", spins_model, got);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      fail_run("timeout, the tests did not finish in time");
    end
  end

  initial begin
    void'($urandom(75913));
    rst_n_i     = 1'b0;
    uart_rx_i   = 1'b1;
    spins_model = '0;
    for (int i = 0; i < ising_pkg::NumSpins; i++) begin
      h_model[i] = 0;
      for (int j = 0; j < ising_pkg::NumSpins; j++) begin
        j_model[i][j] = 0;
      end
    end
    repeat (16) @(posedge clk);
    rst_n_i <= 1'b1;
    test_reset();
    test_spin_write();
    test_ferro_run();
    test_random_problems();
    test_continue_run();
    test_dropped_cmds();
    $display("Regression passed");
    $finish;
  end

endmodule : tb_ising_top

// File: src.f
hw/ising_pkg.sv
hw/uart_pkg.sv
hw/anneal_if.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/ising_regs.sv
hw/anneal_core.sv
hw/ising_top.sv
tb/tb_clock.sv
tb/tb_ising_top.sv

// File: run.sh
#!/bin/sh
# Build and run the Ising machine testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  -f src.f --top-module tb_ising_top -o sim_ising
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_ising > "$LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error status"
fi

cat "$LOG"

if grep -q "Regression passed" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
